/* Bender.yml */
package:
  name: spiCounter

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/spiCounterPkg.sv
      - rtl/spiInputSync.sv
      - rtl/spiSlaveShifter.sv
      - rtl/spiControl.sv
      - rtl/eventCounter.sv
      - rtl/spiCounterTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tbSpiCounter.sv

/* flist.f */
+incdir+include
rtl/spiCounterPkg.sv
rtl/spiInputSync.sv
rtl/spiSlaveShifter.sv
rtl/spiControl.sv
rtl/eventCounter.sv
rtl/spiCounterTop.sv
test/tbSpiCounter.sv

/* include/spiCounter_config.svh */
`ifndef SPICOUNTER_CONFIG_SVH
`define SPICOUNTER_CONFIG_SVH

// stages in each input synchronizer, the top two feed the edge detectors
`define SYNC_DEPTH 3

// event counter and snapshot word width
`define COUNT_WIDTH 32

// command codes, only the first byte of a message is decoded
`define CMD_CLEAR 8'h01   // zero the counter
`define CMD_ENABLE 8'h02  // resume counting
`define CMD_DISABLE 8'h03 // hold the count

// anything else in the first byte is ignored

`endif

/* rtl/eventCounter.sv */
`timescale 1ns/100ps
`include "spiCounter_config.svh"

module eventCounter (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       eventRise,
  input  spiCounterPkg::counterReq_t cReq,
  output spiCounterPkg::counterAck_t cAck,
  output logic                       counting
);

  logic [`COUNT_WIDTH-1:0] count;
  logic [`COUNT_WIDTH-1:0] valueQ; // count captured when the request was served
  logic                    enabled;
  logic                    ackQ;
  logic                    serve;  // new request, not yet acknowledged

  assign serve = cReq.req && !ackQ;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      count   <= '0;
      enabled <= 1'b1; // counting out of reset
      ackQ    <= 1'b0;
    end
    else
    begin
      if (eventRise && enabled)
        count <= count + 1'b1;
      if (serve)
      begin
        ackQ <= 1'b1;  // answer one clk after req is seen
        case (cReq.op)
          spiCounterPkg::opClear:   count   <= '0;   // beats an event in the same cycle
          spiCounterPkg::opEnable:  enabled <= 1'b1;
          spiCounterPkg::opDisable: enabled <= 1'b0;
          default:                  ;                // snapshot leaves state alone
        endcase
      end
      else if (!cReq.req)
        ackQ <= 1'b0;  // phase 4
    end
  end

  always_ff @(posedge clk)
  begin
    if (serve)
      valueQ <= count; // value before the op
  end

  always_comb
  begin
    cAck.ack   = ackQ;
    cAck.value = valueQ;
  end

  assign counting = enabled;

  // req is withdrawn only once it has been acknowledged
  assert property (@(posedge clk) disable iff (reset) $fell(cReq.req) |-> $past(cAck.ack));

endmodule

/* rtl/spiControl.sv */
`timescale 1ns/100ps
`include "spiCounter_config.svh"

module spiControl (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       msgStart,
  input  spiCounterPkg::rxByte_t     rxByte,
  output spiCounterPkg::counterReq_t cReq,
  input  spiCounterPkg::counterAck_t cAck,
  output logic                       loadWord,
  output logic [`COUNT_WIDTH-1:0]    loadValue
);

  logic                      snapPend;  // snapshot waiting for the link
  logic                      cmdPend;   // one command waiting for the link
  spiCounterPkg::counterOp_e cmdOp;
  spiCounterPkg::counterOp_e newOp;
  logic                      known;     // first byte matched a command code
  logic                      newCmd;
  logic                      takeCmd;
  logic                      idle;      // req and ack both low, link free
  logic                      issueSnap;
  logic                      issueCmd;
  logic                      done;      // ack seen for the request in flight

  // command decode
  always_comb
  begin
    newOp = spiCounterPkg::opSnapshot;
    known = 1'b1;
    case (rxByte.data)
      `CMD_CLEAR:   newOp = spiCounterPkg::opClear;
      `CMD_ENABLE:  newOp = spiCounterPkg::opEnable;
      `CMD_DISABLE: newOp = spiCounterPkg::opDisable;
      default:      known = 1'b0; // unknown codes are dropped here
    endcase
  end

  assign newCmd = rxByte.valid && rxByte.first && known; // later bytes never decode

  assign idle      = !cReq.req && !cAck.ack;
  assign done      = cReq.req && cAck.ack;
  assign issueSnap = idle && (msgStart || snapPend);   // snapshot wins over a command
  assign issueCmd  = idle && !msgStart && !snapPend && cmdPend;
  assign takeCmd   = newCmd && (!cmdPend || issueCmd); // a second pending one is lost

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cReq.req <= 1'b0;
      cReq.op  <= spiCounterPkg::opSnapshot;
      snapPend <= 1'b0;
      cmdPend  <= 1'b0;
      loadWord <= 1'b0;
    end
    else
    begin
      loadWord <= 1'b0;
      snapPend <= (snapPend || msgStart) && !issueSnap;
      if (done)
      begin
        cReq.req <= 1'b0;  // phase 3, counter then drops ack
        if (cReq.op == spiCounterPkg::opSnapshot)
          loadWord <= 1'b1;
      end
      else if (issueSnap)
      begin
        cReq.req <= 1'b1;
        cReq.op  <= spiCounterPkg::opSnapshot;
      end
      else if (issueCmd)
      begin
        cReq.req <= 1'b1;
        cReq.op  <= cmdOp;
      end
      if (issueCmd)
        cmdPend <= 1'b0;
      if (takeCmd)
        cmdPend <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (takeCmd)
      cmdOp <= newOp;
    if (done)
      loadValue <= cAck.value; // pre-op count, goes out with loadWord
  end

  // the counter holds ack until the request is withdrawn
  assert property (@(posedge clk) disable iff (reset) cReq.req && cAck.ack |=> cAck.ack);

  // a new request waits for the counter to release ack
  assert property (@(posedge clk) disable iff (reset) $rose(cReq.req) |-> !cAck.ack);

endmodule

/* rtl/spiCounterPkg.sv */
`include "spiCounter_config.svh"

package spiCounterPkg;

  // synchronized view of the spi pins, one-cycle strobes except selActive/mosiBit
  typedef struct packed {
    logic sckRise;   // sck rising edge seen
    logic sckFall;   // sck falling edge seen, sample point
    logic selActive; // ssel low
    logic msgStart;  // ssel falling edge
    logic msgEnd;    // ssel rising edge
    logic mosiBit;   // mosi aligned with the sck edge strobes
  } spiEvents_t;

  // operations the controller can ask of the counter
  typedef enum logic [1:0] {
    opSnapshot = 2'd0,
    opClear    = 2'd1,
    opEnable   = 2'd2,
    opDisable  = 2'd3
  } counterOp_e;

  // request side of the four-phase link, op held stable while req is high
  typedef struct packed {
    logic       req;
    counterOp_e op;
  } counterReq_t;

  // ack side, value is the count before the op and valid while ack is high
  typedef struct packed {
    logic                    ack;
    logic [`COUNT_WIDTH-1:0] value;
  } counterAck_t;

  // received byte, valid for one cycle
  typedef struct packed {
    logic       valid;
    logic       first; // first byte of its message
    logic [7:0] data;
  } rxByte_t;

endpackage

/* rtl/spiCounterTop.sv */
`timescale 1ns/100ps
`include "spiCounter_config.svh"

module spiCounterTop (
  input  logic clk,
  input  logic reset,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  input  logic eventIn,
  output logic miso,
  output logic counting
);

  spiCounterPkg::spiEvents_t   spiEv;
  spiCounterPkg::rxByte_t      rxByte;
  spiCounterPkg::counterReq_t  cReq;
  spiCounterPkg::counterAck_t  cAck;
  logic                        eventRise;
  logic                        msgStart;
  logic                        loadWord;
  logic [`COUNT_WIDTH-1:0]     loadValue;

  // pins into the clk domain
  spiInputSync uSync (
    .clk       (clk),
    .reset     (reset),
    .sck       (sck),
    .ssel      (ssel),
    .mosi      (mosi),
    .eventIn   (eventIn),
    .spiEv     (spiEv),
    .eventRise (eventRise)
  );

  spiSlaveShifter uShifter (
    .clk       (clk),
    .reset     (reset),
    .spiEv     (spiEv),
    .loadWord  (loadWord),
    .loadValue (loadValue),
    .rxByte    (rxByte),
    .msgStart  (msgStart),
    .miso      (miso)
  );

  // command decode and req/ack sequencing
  spiControl uControl (
    .clk       (clk),
    .reset     (reset),
    .msgStart  (msgStart),
    .rxByte    (rxByte),
    .cReq      (cReq),
    .cAck      (cAck),
    .loadWord  (loadWord),
    .loadValue (loadValue)
  );

  eventCounter uCounter (
    .clk       (clk),
    .reset     (reset),
    .eventRise (eventRise),
    .cReq      (cReq),
    .cAck      (cAck),
    .counting  (counting)
  );

endmodule

/* rtl/spiInputSync.sv */
`timescale 1ns/100ps
`include "spiCounter_config.svh"

module spiInputSync (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      sck,
  input  logic                      ssel,
  input  logic                      mosi,
  input  logic                      eventIn,
  output spiCounterPkg::spiEvents_t spiEv,
  output logic                      eventRise
);

  localparam int lastStage = `SYNC_DEPTH - 1; // oldest sample, only used for edge compare

  logic [`SYNC_DEPTH-1:0] sckSync;
  logic [`SYNC_DEPTH-1:0] sselSync;
  logic [`SYNC_DEPTH-1:0] eventSync;
  logic [`SYNC_DEPTH-2:0] mosiSync; // one stage short, data is taken where edges are judged

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sckSync   <= '0;  // mode 0 idles low
      sselSync  <= '1;  // deselected
      eventSync <= '0;
      mosiSync  <= '0;
    end
    else
    begin
      sckSync   <= {sckSync[`SYNC_DEPTH-2:0], sck};
      sselSync  <= {sselSync[`SYNC_DEPTH-2:0], ssel};
      eventSync <= {eventSync[`SYNC_DEPTH-2:0], eventIn};
      mosiSync  <= {mosiSync[`SYNC_DEPTH-3:0], mosi};
    end
  end

  // edges from the two oldest stages, 2 clk behind the pins
  always_comb
  begin
    spiEv.sckRise   = (sckSync[lastStage -: 2] == 2'b01);
    spiEv.sckFall   = (sckSync[lastStage -: 2] == 2'b10);
    spiEv.selActive = ~sselSync[lastStage-1]; // active low
    spiEv.msgStart  = (sselSync[lastStage -: 2] == 2'b10);
    spiEv.msgEnd    = (sselSync[lastStage -: 2] == 2'b01);
    spiEv.mosiBit   = mosiSync[lastStage-1];  // same age as the sck edge compare
  end

  assign eventRise = (eventSync[lastStage -: 2] == 2'b01);

  // mode 0 keeps sck low whenever ssel changes
  assert property (@(posedge clk) disable iff (reset)
    (spiEv.msgStart || spiEv.msgEnd) |-> !sckSync[lastStage-1]);

endmodule

/* rtl/spiSlaveShifter.sv */
`timescale 1ns/100ps
`include "spiCounter_config.svh"

module spiSlaveShifter (
  input  logic                      clk,
  input  logic                      reset,
  input  spiCounterPkg::spiEvents_t spiEv,
  input  logic                      loadWord,
  input  logic [`COUNT_WIDTH-1:0]   loadValue,
  output spiCounterPkg::rxByte_t    rxByte,
  output logic                      msgStart,
  output logic                      miso
);

  logic [2:0]              bitCnt;    // bit position within the current byte
  logic                    firstDone; // first byte of this message already delivered
  logic                    txArmed;   // a falling edge has been seen in this message
  logic                    byteDone;
  logic [7:0]              rxShift;
  logic                    rxValid;
  logic                    rxFirst;
  logic [`COUNT_WIDTH-1:0] txShift;

  // eighth falling edge of a byte
  assign byteDone = spiEv.selActive && spiEv.sckFall && (bitCnt == 3'd7);

  // bit and byte tracking, everything restarts while deselected
  always_ff @(posedge clk)
  begin
    if (reset || !spiEv.selActive)
    begin
      bitCnt    <= 3'd0;
      firstDone <= 1'b0;
      txArmed   <= 1'b0;
    end
    else if (spiEv.sckFall)
    begin
      bitCnt  <= bitCnt + 3'd1; // wraps at byte boundary
      txArmed <= 1'b1;
      if (bitCnt == 3'd7)
        firstDone <= 1'b1;
    end
  end

  // receive shift, msb first
  always_ff @(posedge clk)
  begin
    if (spiEv.selActive && spiEv.sckFall)
      rxShift <= {rxShift[6:0], spiEv.mosiBit};
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rxValid  <= 1'b0;
      rxFirst  <= 1'b0;
      msgStart <= 1'b0;
    end
    else
    begin
      rxValid  <= byteDone;               // one cycle after the eighth fall
      rxFirst  <= byteDone && !firstDone;
      msgStart <= spiEv.msgStart;         // delayed so the bit state is already cleared
    end
  end

  always_comb
  begin
    rxByte.valid = rxValid;
    rxByte.first = rxFirst;
    rxByte.data  = rxShift; // complete once rxValid is high
  end

  // transmit word, zero fill behind the msb.
  // The first rise of a message does not shift: the master samples bit 31 on the first fall.
  always_ff @(posedge clk)
  begin
    if (reset || !spiEv.selActive)
      txShift <= '0;  // idle low between messages
    else if (loadWord)
      txShift <= loadValue;
    else if (spiEv.sckRise && txArmed)
      txShift <= {txShift[`COUNT_WIDTH-2:0], 1'b0};
  end

  assign miso = txShift[`COUNT_WIDTH-1]; // msb first, no tri-state with a single slave

  // the snapshot must land inside the message it was taken for
  assert property (@(posedge clk) disable iff (reset) loadWord |-> spiEv.selActive);

endmodule

/* test/tbSpiCounter.sv */
`timescale 1ns/100ps
`include "spiCounter_config.svh"

module tbSpiCounter;

  localparam int clkPeriod = 4;             // ns
  localparam int maxBytes  = 8;             // longest message, reads a whole second word
  localparam int frameBits = maxBytes * 8;
  localparam int maxEvents = 24;            // upper bound of one random burst
  localparam int numMsgs   = 14;
  // 12 clk per bit, select setup and gap, worst-case burst before each message
  localparam int msgClk    = frameBits * 12 + 40 + maxEvents * 4;
  localparam int limitNs   = (numMsgs * msgClk + 200) * clkPeriod;

  logic clk;
  logic reset;
  logic sck;
  logic ssel;
  logic mosi;
  logic eventIn;
  logic miso;
  logic counting;

  integer                  seed;
  int                      pendingEvents; // pulses driven since the last message
  logic [`COUNT_WIDTH-1:0] modelCount;
  logic                    modelEnable;
  int                      checksQueued;
  int                      checksDone;
  int                      errorCount;

  // results waiting for the compare process
  string                   nameQ[$];
  bit                      flagQ[$];      // 1 for the counting output, 0 for a count
  logic [`COUNT_WIDTH-1:0] expQ[$];
  logic [`COUNT_WIDTH-1:0] actQ[$];

  spiCounterTop dut (
    .clk      (clk),
    .reset    (reset),
    .sck      (sck),
    .ssel     (ssel),
    .mosi     (mosi),
    .eventIn  (eventIn),
    .miso     (miso),
    .counting (counting)
  );

  always #(clkPeriod / 2) clk = ~clk;

  // expected snapshot for a message, then the effect of its first byte
  function automatic logic [`COUNT_WIDTH-1:0] refModel(input int events, input logic [7:0] cmd);
    logic [`COUNT_WIDTH-1:0] snap;
    if (modelEnable)
      modelCount = modelCount + events; // events only land while enabled
    snap = modelCount;                  // captured at ssel fall, before the command
    case (cmd)
      `CMD_CLEAR:   modelCount = '0;
      `CMD_ENABLE:  modelEnable = 1'b1;
      `CMD_DISABLE: modelEnable = 1'b0;
      default:      ;
    endcase
    return snap;
  endfunction

  task automatic checkCount(input string testName, input logic [`COUNT_WIDTH-1:0] expected,
                            input logic [`COUNT_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
      errorCount++;
      $display("FAILED %s: expected 0x%08h, actual 0x%08h", testName, expected, actual);
      $display("Errors found");
      $fatal(1, "count mismatch in %s", testName);
    end
  endtask

  task automatic checkFlag(input string testName, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      errorCount++;
      $display("FAILED %s: expected %b, actual %b", testName, expected, actual);
      $display("Errors found");
      $fatal(1, "flag mismatch in %s", testName);
    end
  endtask

  task automatic queueCheck(input string testName, input bit isFlag,
                            input logic [`COUNT_WIDTH-1:0] expected,
                            input logic [`COUNT_WIDTH-1:0] actual);
    nameQ.push_back(testName);
    flagQ.push_back(isFlag);
    expQ.push_back(expected);
    actQ.push_back(actual);
    checksQueued++;
  endtask

  // returns on a falling clk edge, where every input is driven
  task automatic waitClk(input int n);
    repeat (n) @(negedge clk);
  endtask

  // mode 0 master, 6 clk per sck half period, bytes msb first from the top of txData
  task automatic spiMessage(input int nBytes, input logic [frameBits-1:0] txData,
                            output logic [frameBits-1:0] rxData);
    int i;
    rxData = '0;
    waitClk(1);
    ssel = 1'b0;
    waitClk(10);                    // snapshot lands on miso in this gap
    for (i = 0; i < nBytes * 8; i++)
    begin
      mosi = txData[frameBits-1-i]; // mid low phase, clear of the last fall
      waitClk(3);
      sck = 1'b1;
      waitClk(6);
      rxData = {rxData[frameBits-2:0], miso}; // sampled at the falling sck
      sck = 1'b0;
      waitClk(3);
    end
    waitClk(4);
    ssel = 1'b1;
    mosi = 1'b0;
    waitClk(8);                     // command long settled by now
  endtask

  task automatic driveEvents(input int n);
    repeat (n)
    begin
      eventIn = 1'b1;
      waitClk(2);
      eventIn = 1'b0;
      waitClk(2);
    end
    pendingEvents += n;
    waitClk(2);
  endtask

  task automatic randomEvents();
    int n;
    n = 1 + ($unsigned($random(seed)) % maxEvents);
    driveEvents(n);
  endtask

  // one message, checks the read word, the counting output and any trailing bits
  task automatic runMessage(input string testName, input int nBytes,
                            input logic [frameBits-1:0] txData);
    logic [frameBits-1:0]    rxData;
    logic [frameBits-1:0]    shifted;
    logic [`COUNT_WIDTH-1:0] expSnap;
    logic [`COUNT_WIDTH-1:0] tail;
    int                      i;
    expSnap = refModel(pendingEvents, txData[frameBits-1 -: 8]);
    pendingEvents = 0;
    spiMessage(nBytes, txData, rxData);
    shifted = rxData >> ((nBytes - 4) * 8); // first 32 bits read
    queueCheck({testName, " count"}, 1'b0, expSnap, shifted[`COUNT_WIDTH-1:0]);
    queueCheck({testName, " counting"}, 1'b1, {31'd0, modelEnable}, {31'd0, counting});
    if (nBytes > 4)
    begin
      tail = '0;
      for (i = 0; i < (nBytes - 4) * 8; i++)
        tail[i] = rxData[i];
      queueCheck({testName, " tail"}, 1'b0, '0, tail); // zeros after bit 32
    end
  endtask

  initial
  begin : compareProc
    string                   name;
    bit                      isFlag;
    logic [`COUNT_WIDTH-1:0] expV;
    logic [`COUNT_WIDTH-1:0] actV;
    forever
    begin
      wait (nameQ.size() != 0);
      name   = nameQ.pop_front();
      isFlag = flagQ.pop_front();
      expV   = expQ.pop_front();
      actV   = actQ.pop_front();
      if (isFlag)
        checkFlag(name, expV[0], actV[0]);
      else
        checkCount(name, expV, actV);
      checksDone++;
    end
  end

  initial
  begin : watchdog
    #(limitNs);
    $display("Timeout: the run did not finish within %0d ns", limitNs);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    clk           = 1'b0;
    reset         = 1'b1;
    sck           = 1'b0;
    ssel          = 1'b1;
    mosi          = 1'b0;
    eventIn       = 1'b0;
    seed          = 32'ha4d68190;
    pendingEvents = 0;
    modelCount    = '0;
    modelEnable   = 1'b1; // counting out of reset
    checksQueued  = 0;
    checksDone    = 0;
    errorCount    = 0;
    waitClk(2);           // two rising edges in reset
    reset = 1'b0;
    waitClk(4);

    runMessage("reset read", 4, '0);
    repeat (3)
    begin
      randomEvents();
      runMessage("accumulate", 4, '0);
    end

    randomEvents();
    runMessage("clear same message", 4, {`CMD_CLEAR, 56'h0}); // still pre-clear
    randomEvents();
    runMessage("after clear", 4, '0);

    randomEvents();
    runMessage("disable", 4, {`CMD_DISABLE, 56'h0});
    randomEvents();       // dropped by the counter
    runMessage("while disabled", 4, '0);
    runMessage("enable", 4, {`CMD_ENABLE, 56'h0});
    randomEvents();
    runMessage("resumed", 4, '0);

    randomEvents();
    runMessage("unknown command", 4, {8'ha5, 56'h0});
    runMessage("late command bytes", 4,
               {8'h00, `CMD_CLEAR, `CMD_DISABLE, `CMD_CLEAR, 32'h0});
    randomEvents();
    runMessage("after late commands", 4, '0);

    randomEvents();
    runMessage("zero tail", 8, '0); // a full second word, a wrapped count would show

    wait (checksDone == checksQueued);
    if (errorCount == 0)
    begin
      $display("No errors");
      $finish;
    end
    else
    begin
      $display("Errors found");
      $fatal(1, "%0d checks failed", errorCount);
    end
  end

endmodule
